// File: common/asteroid_pkg.sv
`default_nettype none

package asteroid_pkg;

        localparam int lane_count = 8;
        localparam int lane_bits = 3;
        localparam int distance_bits = 4;
        localparam int score_bits = 8;

        // cycles counted after a launch before the same launch is allowed again
        localparam int shot_cooldown = 64;
        localparam int special_cooldown = 256;

        typedef logic [lane_bits-1:0] lane_t;
        typedef logic [distance_bits-1:0] distance_t;

        // on clear, the asteroid of lane i starts at distance i + 1
        localparam distance_t respawn_distance = distance_t'(15);
        localparam logic [1:0] initial_lives = 2'd3;

        typedef struct packed {
                logic fire;
                logic special;
                lane_t lane;
        } player_cmd_t;

        typedef struct packed {
                logic [1:0] lives;
                logic [score_bits-1:0] score;
                logic game_over;
        } game_status_t;

        // encoding is also what the debug port shows
        typedef enum logic [4:0] {
                state_idle           = 5'd0,
                state_init           = 5'd1,
                state_wait_move      = 5'd2,
                state_capture        = 5'd3,
                state_settle         = 5'd4,
                state_settle2        = 5'd5,
                state_advance        = 5'd6,
                state_decide         = 5'd7,
                state_launch_shot    = 5'd8,
                state_launch_special = 5'd9,
                state_wait_launch    = 5'd10,
                state_game_over      = 5'd11,
                state_error          = 5'd31
        } control_state_t;

endpackage

`default_nettype wire

// File: game_control/game_control.sv
`timescale 1ns/10ps
`default_nettype none

module game_control (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic start,
        input  wire logic cmd_valid,
        input  wire asteroid_pkg::player_cmd_t cmd,
        input  wire logic shot_ready,
        input  wire logic special_ready,
        input  wire logic [1:0] lives,
        input  wire logic launch_done,
        output logic clear,
        output logic capture_enable,
        output logic advance,
        output logic launch_shot,
        output logic launch_special,
        output logic awaiting_move,
        output logic game_over,
        output asteroid_pkg::control_state_t debug_state
);

        asteroid_pkg::control_state_t state;
        asteroid_pkg::control_state_t next_state;
        logic out_of_lives;

        assign out_of_lives = (lives == 2'd0);

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        state <= asteroid_pkg::state_idle;
                else
                        state <= next_state;
        end

        always_comb begin
                case (state)
                        asteroid_pkg::state_idle:
                                next_state = start ? asteroid_pkg::state_init
                                                   : asteroid_pkg::state_idle;
                        asteroid_pkg::state_init:
                                next_state = asteroid_pkg::state_wait_move;
                        asteroid_pkg::state_wait_move:
                                next_state = out_of_lives ? asteroid_pkg::state_game_over :
                                             cmd_valid    ? asteroid_pkg::state_capture
                                                          : asteroid_pkg::state_wait_move;
                        asteroid_pkg::state_capture:
                                next_state = asteroid_pkg::state_settle;
                        asteroid_pkg::state_settle:
                                next_state = asteroid_pkg::state_settle2;
                        asteroid_pkg::state_settle2:
                                next_state = asteroid_pkg::state_advance;
                        asteroid_pkg::state_advance:
                                next_state = asteroid_pkg::state_decide;
                        // lives here already reflect the advance
                        asteroid_pkg::state_decide:
                                next_state = out_of_lives ? asteroid_pkg::state_game_over :
                                             (cmd.special && special_ready) ?
                                                     asteroid_pkg::state_launch_special :
                                             (cmd.fire && shot_ready) ?
                                                     asteroid_pkg::state_launch_shot :
                                                     asteroid_pkg::state_wait_move;
                        asteroid_pkg::state_launch_shot:
                                next_state = asteroid_pkg::state_wait_launch;
                        asteroid_pkg::state_launch_special:
                                next_state = asteroid_pkg::state_wait_launch;
                        asteroid_pkg::state_wait_launch:
                                next_state = launch_done ? asteroid_pkg::state_wait_move
                                                         : asteroid_pkg::state_wait_launch;
                        // left only through reset
                        asteroid_pkg::state_game_over:
                                next_state = asteroid_pkg::state_game_over;
                        default:
                                next_state = asteroid_pkg::state_error;
                endcase
        end

        // moore outputs
        always_comb begin
                clear          = (state == asteroid_pkg::state_init);
                capture_enable = (state == asteroid_pkg::state_capture);
                advance        = (state == asteroid_pkg::state_advance);
                launch_shot    = (state == asteroid_pkg::state_launch_shot);
                launch_special = (state == asteroid_pkg::state_launch_special);
                awaiting_move  = (state == asteroid_pkg::state_wait_move);
                game_over      = (state == asteroid_pkg::state_game_over);
        end

        assign debug_state = state;

        // the spawner runs one sweep at a time, so only one kind of launch per turn
        assert property (@(posedge clock) disable iff (reset)
                !(launch_shot && launch_special))
                else $error("game_control: shot and special launched together");

        assert property (@(posedge clock) disable iff (reset)
                !$isunknown(state) && state != asteroid_pkg::state_error)
                else $error("game_control: unknown state %h", state);

endmodule

`default_nettype wire

// File: source/command_capture.sv
`timescale 1ns/10ps
`default_nettype none

module command_capture (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic clear,
        input  wire logic capture_enable,
        input  wire asteroid_pkg::player_cmd_t cmd_in,
        input  wire logic launch_shot,
        input  wire logic launch_special,
        output asteroid_pkg::player_cmd_t cmd,
        output logic shot_ready,
        output logic special_ready
);

        typedef logic [$clog2(asteroid_pkg::special_cooldown + 1)-1:0] count_t;

        logic [1:0] launch;
        logic [1:0] ready;

        function automatic count_t limit_of(input int idx);
                return (idx == 0) ? count_t'(asteroid_pkg::shot_cooldown)
                                  : count_t'(asteroid_pkg::special_cooldown);
        endfunction

        // held command, read by the controller and the spawner during the turn
        always_ff @(posedge clock) begin
                if (capture_enable)
                        cmd <= cmd_in;
        end

        // timer 0 guards the shot, timer 1 the special
        assign launch = {launch_special, launch_shot};

        for (genvar i = 0; i < 2; i++) begin : g_timer
                count_t count;

                // saturates at its limit, where it reads as ready
                always_ff @(posedge clock or posedge reset) begin
                        if (reset)
                                count <= limit_of(i);
                        else if (clear)
                                count <= limit_of(i);
                        else if (launch[i])
                                count <= '0;
                        else if (!ready[i])
                                count <= count + 1'b1;
                end

                assign ready[i] = (count == limit_of(i));
        end

        assign shot_ready = ready[0];
        assign special_ready = ready[1];

endmodule

`default_nettype wire

// File: source/asteroid_field.sv
`timescale 1ns/10ps
`default_nettype none

module asteroid_field (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic clear,
        input  wire logic advance,
        input  wire logic strike,
        input  wire asteroid_pkg::lane_t strike_lane,
        output logic [1:0] lives,
        output logic [asteroid_pkg::score_bits-1:0] score
);

        asteroid_pkg::distance_t distance [asteroid_pkg::lane_count];
        asteroid_pkg::distance_t distance_next [asteroid_pkg::lane_count];
        logic [asteroid_pkg::lane_count-1:0] strike_mask;
        logic [$clog2(asteroid_pkg::lane_count + 1)-1:0] hit_count;

        always_comb begin
                strike_mask = '0;
                if (strike)
                        strike_mask[strike_lane] = 1'b1;
        end

        // per lane next distance and number of asteroids that reached the player
        always_comb begin
                hit_count = '0;
                for (int i = 0; i < asteroid_pkg::lane_count; i++) begin
                        distance_next[i] = distance[i];
                        if (advance) begin
                                // distance 1 or 0 reaches the player on this step
                                if (distance[i][asteroid_pkg::distance_bits-1:1] == '0) begin
                                        distance_next[i] = asteroid_pkg::respawn_distance;
                                        hit_count = hit_count + 1'b1;
                                end else begin
                                        distance_next[i] = distance[i] - 1'b1;
                                end
                        end
                        if (strike_mask[i])
                                distance_next[i] = asteroid_pkg::respawn_distance;
                end
        end

        always_ff @(posedge clock) begin
                for (int i = 0; i < asteroid_pkg::lane_count; i++) begin
                        if (clear)
                                distance[i] <= asteroid_pkg::distance_t'(i + 1);
                        else
                                distance[i] <= distance_next[i];
                end
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        lives <= asteroid_pkg::initial_lives;
                        score <= '0;
                end else if (clear) begin
                        lives <= asteroid_pkg::initial_lives;
                        score <= '0;
                end else begin
                        // lives saturate at zero
                        if (lives > hit_count)
                                lives <= lives - hit_count[1:0];
                        else
                                lives <= 2'd0;
                        if (strike && score != '1)
                                score <= score + 1'b1;
                end
        end

endmodule

`default_nettype wire

// File: source/projectile_spawner.sv
`timescale 1ns/10ps
`default_nettype none

module projectile_spawner (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic launch_shot,
        input  wire logic launch_special,
        input  wire asteroid_pkg::lane_t lane,
        output logic strike,
        output asteroid_pkg::lane_t strike_lane,
        output logic launch_done
);

        logic launch;
        logic active;
        logic special_mode;
        logic use_special;
        asteroid_pkg::lane_t index;

        assign launch = launch_shot || launch_special;

        // lane 0 is visited in the launch cycle itself, lanes 1..7 follow from the index
        assign use_special = launch ? launch_special : special_mode;
        assign strike_lane = active ? index : '0;
        assign strike = (launch || active) && (use_special || strike_lane == lane);

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        active <= 1'b0;
                        special_mode <= 1'b0;
                        index <= '0;
                        launch_done <= 1'b0;
                end else begin
                        launch_done <= 1'b0;
                        if (launch) begin
                                active <= 1'b1;
                                special_mode <= launch_special;
                                index <= asteroid_pkg::lane_t'(1);
                        end else if (active) begin
                                if (index == asteroid_pkg::lane_t'(asteroid_pkg::lane_count - 1)) begin
                                        active <= 1'b0;
                                        launch_done <= 1'b1;
                                end else begin
                                        index <= index + 1'b1;
                                end
                        end
                end
        end

        // the controller must wait for launch_done before the next launch
        assert property (@(posedge clock) disable iff (reset) launch |-> !active)
                else $error("projectile_spawner: launch while a sweep is running");

endmodule

`default_nettype wire

// File: source/asteroid_game.sv
`timescale 1ns/10ps
`default_nettype none

module asteroid_game (
        input  wire logic clock,
        input  wire logic reset,
        input  wire logic start,
        input  wire logic cmd_valid,
        input  wire asteroid_pkg::player_cmd_t cmd,
        output asteroid_pkg::game_status_t status,
        output logic awaiting_move,
        output asteroid_pkg::control_state_t debug_state
);

        asteroid_pkg::player_cmd_t held_cmd;
        asteroid_pkg::lane_t strike_lane;
        logic clear;
        logic capture_enable;
        logic advance;
        logic launch_shot;
        logic launch_special;
        logic game_over;
        logic shot_ready;
        logic special_ready;
        logic launch_done;
        logic strike;
        logic [1:0] lives;
        logic [asteroid_pkg::score_bits-1:0] score;

        game_control control_i (
                .clock          (clock),
                .reset          (reset),
                .start          (start),
                .cmd_valid      (cmd_valid),
                .cmd            (held_cmd),
                .shot_ready     (shot_ready),
                .special_ready  (special_ready),
                .lives          (lives),
                .launch_done    (launch_done),
                .clear          (clear),
                .capture_enable (capture_enable),
                .advance        (advance),
                .launch_shot    (launch_shot),
                .launch_special (launch_special),
                .awaiting_move  (awaiting_move),
                .game_over      (game_over),
                .debug_state    (debug_state)
        );

        command_capture capture_i (
                .clock          (clock),
                .reset          (reset),
                .clear          (clear),
                .capture_enable (capture_enable),
                .cmd_in         (cmd),
                .launch_shot    (launch_shot),
                .launch_special (launch_special),
                .cmd            (held_cmd),
                .shot_ready     (shot_ready),
                .special_ready  (special_ready)
        );

        projectile_spawner spawner_i (
                .clock          (clock),
                .reset          (reset),
                .launch_shot    (launch_shot),
                .launch_special (launch_special),
                .lane           (held_cmd.lane),
                .strike         (strike),
                .strike_lane    (strike_lane),
                .launch_done    (launch_done)
        );

        asteroid_field field_i (
                .clock       (clock),
                .reset       (reset),
                .clear       (clear),
                .advance     (advance),
                .strike      (strike),
                .strike_lane (strike_lane),
                .lives       (lives),
                .score       (score)
        );

        always_comb begin
                status.lives = lives;
                status.score = score;
                status.game_over = game_over;
        end

endmodule

`default_nettype wire

// File: dv/tb_asteroid_game.sv
`timescale 1ns/10ps
`default_nettype none

module tb_asteroid_game;

        localparam int turn_timeout = 100;

        logic clock;
        logic reset;
        logic start;
        logic cmd_valid;
        asteroid_pkg::player_cmd_t cmd;
        asteroid_pkg::game_status_t status;
        logic awaiting_move;
        asteroid_pkg::control_state_t debug_state;

        integer seed = 32'h9480_2835;
        int cycle_count = 0;

        // reference model of the field and the two cooldowns
        int model_distance [asteroid_pkg::lane_count];
        int model_lives;
        int model_score;
        int model_game_over;
        int last_shot_cycle;
        int last_special_cycle;

        asteroid_game dut_i (
                .clock         (clock),
                .reset         (reset),
                .start         (start),
                .cmd_valid     (cmd_valid),
                .cmd           (cmd),
                .status        (status),
                .awaiting_move (awaiting_move),
                .debug_state   (debug_state)
        );

        initial begin
                clock = 1'b0;
                forever #2 clock = ~clock;
        end

        always @(posedge clock) cycle_count <= cycle_count + 1;

        task automatic stop_with_failure(input string what);
                $display("%s", what);
                $display("Verification failed");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_value(input string name, input int expected, input int actual);
                assert (actual == expected)
                else stop_with_failure($sformatf("[ERROR] %s: expected %h, got %h",
                                                 name, expected, actual));
        endtask

        task automatic check_status();
                check_value("status.lives", model_lives, status.lives);
                check_value("status.score", model_score, status.score);
                check_value("status.game_over", model_game_over, status.game_over);
        endtask

        task automatic next_cycle();
                @(posedge clock);
                #1;
        endtask

        // returns once the controller waits for a move or the game has ended
        task automatic wait_for_move();
                int waited;
                waited = 0;
                while (!awaiting_move && !status.game_over) begin
                        if (waited >= turn_timeout)
                                stop_with_failure("timeout while waiting for awaiting_move");
                        next_cycle();
                        waited++;
                end
        endtask

        function automatic asteroid_pkg::lane_t random_lane();
                return asteroid_pkg::lane_t'($random(seed));
        endfunction

        // lane whose asteroid is closest once the coming advance is applied
        function automatic asteroid_pkg::lane_t next_threat_lane();
                asteroid_pkg::lane_t best;
                int best_distance;
                int after;
                best = '0;
                best_distance = 99;
                for (int i = 0; i < asteroid_pkg::lane_count; i++) begin
                        after = (model_distance[i] <= 1) ? 15 : model_distance[i] - 1;
                        if (after < best_distance) begin
                                best_distance = after;
                                best = asteroid_pkg::lane_t'(i);
                        end
                end
                return best;
        endfunction

        function automatic void model_strike(input int lane);
                model_distance[lane] = 15;
                if (model_score < 255)
                        model_score++;
        endfunction

        // one turn, where issue is the cycle in which cmd_valid is sampled
        function automatic void model_turn(input logic fire, input logic special,
                                           input int lane, input int issue);
                int decide_cycle;
                int hits;
                int since_shot;
                int since_special;
                decide_cycle = issue + 5;
                hits = 0;
                since_shot = decide_cycle - last_shot_cycle - 1;
                since_special = decide_cycle - last_special_cycle - 1;
                for (int i = 0; i < asteroid_pkg::lane_count; i++) begin
                        if (model_distance[i] <= 1) begin
                                model_distance[i] = 15;
                                hits++;
                        end else begin
                                model_distance[i]--;
                        end
                end
                model_lives = (model_lives > hits) ? model_lives - hits : 0;
                if (model_lives == 0) begin
                        model_game_over = 1;
                end else if (special && since_special >= asteroid_pkg::special_cooldown) begin
                        for (int i = 0; i < asteroid_pkg::lane_count; i++)
                                model_strike(i);
                        last_special_cycle = decide_cycle + 1;
                end else if (fire && since_shot >= asteroid_pkg::shot_cooldown) begin
                        model_strike(lane);
                        last_shot_cycle = decide_cycle + 1;
                end
        endfunction

        task automatic restart_game();
                reset = 1'b1;
                start = 1'b0;
                cmd_valid = 1'b0;
                cmd = '0;
                repeat (8) @(posedge clock);
                #1;
                reset = 1'b0;
                check_value("awaiting_move", 0, awaiting_move);
                check_value("status.lives", 3, status.lives);
                check_value("status.score", 0, status.score);
                start = 1'b1;
                next_cycle();
                start = 1'b0;
                for (int i = 0; i < asteroid_pkg::lane_count; i++)
                        model_distance[i] = i + 1;
                model_lives = 3;
                model_score = 0;
                model_game_over = 0;
                last_shot_cycle = -1000;
                last_special_cycle = -1000;
                wait_for_move();
                check_value("awaiting_move", 1, awaiting_move);
                check_status();
        endtask

        task automatic send_command(input logic fire, input logic special,
                                    input asteroid_pkg::lane_t lane);
                int issue;
                check_value("awaiting_move", 1, awaiting_move);
                cmd.fire = fire;
                cmd.special = special;
                cmd.lane = lane;
                cmd_valid = 1'b1;
                issue = cycle_count;
                next_cycle();
                cmd_valid = 1'b0;
                model_turn(fire, special, lane, issue);
                wait_for_move();
                check_status();
        endtask

        task automatic test_plain_turn();
                send_command(1'b0, 1'b0, random_lane());
                check_value("status.lives", 2, status.lives);
        endtask

        task automatic test_shot_cooldown();
                int score_before;
                restart_game();
                score_before = model_score;
                // hit the lane that would reach the player next, so the game goes on
                send_command(1'b1, 1'b0, next_threat_lane());
                check_value("status.score", score_before + 1, status.score);
                send_command(1'b1, 1'b0, random_lane());
                check_value("status.score", score_before + 1, status.score);
                repeat (70) next_cycle();
                send_command(1'b1, 1'b0, random_lane());
                check_value("status.score", score_before + 2, status.score);
        endtask

        task automatic test_special_cooldown();
                int score_before;
                restart_game();
                score_before = model_score;
                send_command(1'b0, 1'b1, random_lane());
                check_value("status.score", score_before + 8, status.score);
                send_command(1'b0, 1'b1, random_lane());
                check_value("status.score", score_before + 8, status.score);
                repeat (260) next_cycle();
                send_command(1'b0, 1'b1, random_lane());
                check_value("status.score", score_before + 16, status.score);
        endtask

        task automatic test_game_over();
                int turns;
                restart_game();
                turns = 0;
                while (!status.game_over) begin
                        if (turns >= 8)
                                stop_with_failure("the game did not end after eight plain turns");
                        send_command(1'b0, 1'b0, random_lane());
                        turns++;
                end
                check_value("debug_state", asteroid_pkg::state_game_over, debug_state);
                // commands and start are both ignored until reset
                repeat (4) begin
                        cmd.fire = 1'b1;
                        cmd.special = 1'b1;
                        cmd.lane = random_lane();
                        cmd_valid = 1'b1;
                        start = 1'b1;
                        next_cycle();
                        cmd_valid = 1'b0;
                        start = 1'b0;
                        repeat (10) begin
                                next_cycle();
                                check_value("awaiting_move", 0, awaiting_move);
                        end
                        check_status();
                end
        endtask

        initial begin
                reset = 1'b1;
                start = 1'b0;
                cmd_valid = 1'b0;
                cmd = '0;
                restart_game();
                test_plain_turn();
                test_shot_cooldown();
                test_special_cooldown();
                test_game_over();
                $display("Verification passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: src.f
common/asteroid_pkg.sv
game_control/game_control.sv
source/command_capture.sv
source/asteroid_field.sv
source/projectile_spawner.sv
source/asteroid_game.sv
dv/tb_asteroid_game.sv

// File: run.sh
#!/bin/sh
# build the asteroid game testbench with Verilator and run it
cd "$(dirname "$0")" \
        && verilator --binary --timing --assert -Wno-fatal -f src.f \
                --top-module tb_asteroid_game -o sim_asteroid_game \
        && ./obj_dir/sim_asteroid_game || exit 1
